// File: design/netmod_settings.svh
// Network module header path parameters
// Packet limits, channel layout and register reset values
`ifndef NETMOD_SETTINGS_SVH
`define NETMOD_SETTINGS_SVH

// Largest accepted packet length in bytes
`define NETMOD_PKT_MTU 16383
`define NETMOD_LEN_WIDTH 14

// DMA channel count, must be a power of two
`define NETMOD_CHANNELS 8
`define NETMOD_CHAN_WIDTH 3

`define NETMOD_META_WIDTH 8

// Register reset values
`define NETMOD_CTRL_RESET 2'b11
`define NETMOD_MIN_LEN_RESET 64
`define NETMOD_CHAN_BASE_RESET 0

`endif

// File: design/netmod_pkg.sv
// Shared types and MI register map for the network module header path
`include "netmod_settings.svh"

package netmod_pkg;

    typedef logic [`NETMOD_LEN_WIDTH-1:0]  pktLen_t;
    typedef logic [`NETMOD_CHAN_WIDTH-1:0] dmaChannel_t;
    typedef logic [`NETMOD_META_WIDTH-1:0] pktMeta_t;
    typedef logic [31:0]                   miAddr_t;
    typedef logic [31:0]                   miData_t;
    typedef logic [31:0]                   pktCount_t;

    // ========================================
    // MI register map
    // ========================================
    localparam miAddr_t regCtrl     = 32'h00;
    localparam miAddr_t regMinLen   = 32'h04;
    localparam miAddr_t regChanBase = 32'h08;
    localparam miAddr_t regRxPkts   = 32'h10;
    localparam miAddr_t regRxDisc   = 32'h14;
    localparam miAddr_t regTxPkts   = 32'h18;
    localparam miAddr_t regTxDrop   = 32'h1C;
    localparam miAddr_t regCntClr   = 32'h20;

endpackage

// File: design/rxHeaderPath.sv
// Receive header stage, Ethernet to DMA
// Picks the DMA channel and flags headers to be discarded
`timescale 1ns/1ps
`include "netmod_settings.svh"

module rxHeaderPath import netmod_pkg::*; (
    input  logic        clk,
    input  logic        rstN,

    // Ethernet receive headers
    input  logic        ethRxValid,
    input  pktLen_t     ethRxLength,
    input  pktMeta_t    ethRxMeta,
    input  logic        ethRxError,

    // Control levels from the register file
    input  logic        rxEnable,
    input  pktLen_t     minLength,
    input  dmaChannel_t channelBase,

    // DMA receive headers
    output logic        dmaRxValid,
    output pktLen_t     dmaRxLength,
    output dmaChannel_t dmaRxChannel,
    output pktMeta_t    dmaRxMeta,
    output logic        dmaRxDiscard,

    // Counter strobes
    output logic        rxCountStrobe,
    output logic        rxDiscardStrobe
);

    dmaChannel_t channelNext;
    logic        discardNext;
    logic        tooShort;
    logic        tooLong;

    // ========================================
    // Channel and discard decision
    // ========================================

    // Sum wraps by itself since the channel count is a power of two
    assign channelNext = dmaChannel_t'(ethRxMeta[`NETMOD_CHAN_WIDTH-1:0]) + channelBase;

    assign tooShort    = ethRxLength < minLength;
    assign tooLong     = ethRxLength > pktLen_t'(`NETMOD_PKT_MTU);
    assign discardNext = ethRxError || !rxEnable || tooShort || tooLong;

    // ========================================
    // Output stage
    // ========================================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dmaRxValid <= 1'b0;
        end else begin
            dmaRxValid <= ethRxValid;
        end
    end

    always_ff @(posedge clk) begin
        if (ethRxValid) begin
            dmaRxLength  <= ethRxLength;
            dmaRxChannel <= channelNext;
            dmaRxMeta    <= ethRxMeta;
            dmaRxDiscard <= discardNext;
        end
    end

    // Counters see the header on the cycle it arrives
    assign rxCountStrobe   = ethRxValid;
    assign rxDiscardStrobe = ethRxValid && discardNext;

endmodule

// File: design/txHeaderPath.sv
// Transmit header stage, DMA to Ethernet
// Strips the DMA channel and drops headers while transmit is disabled
`timescale 1ns/1ps

module txHeaderPath import netmod_pkg::*; (
    input  logic        clk,
    input  logic        rstN,

    // DMA transmit headers
    input  logic        dmaTxValid,
    input  pktLen_t     dmaTxLength,
    input  dmaChannel_t dmaTxChannel,
    input  pktMeta_t    dmaTxMeta,

    input  logic        txEnable,

    // Ethernet transmit headers
    output logic        ethTxValid,
    output pktLen_t     ethTxLength,
    output pktMeta_t    ethTxMeta,

    // Counter strobes
    output logic        txCountStrobe,
    output logic        txDropStrobe
);

    logic passHeader;

    // Channel is not part of the Ethernet header and is not stored
    assign passHeader = dmaTxValid && txEnable;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ethTxValid <= 1'b0;
        end else begin
            ethTxValid <= passHeader;
        end
    end

    always_ff @(posedge clk) begin
        if (passHeader) begin
            ethTxLength <= dmaTxLength;
            ethTxMeta   <= dmaTxMeta;
        end
    end

    assign txCountStrobe = passHeader;
    assign txDropStrobe  = dmaTxValid && !txEnable;

endmodule

// File: design/miRegisters.sv
// MI register file with control registers and packet counters
`timescale 1ns/1ps
`include "netmod_settings.svh"

module miRegisters import netmod_pkg::*; (
    input  logic        clk,
    input  logic        rstN,

    // MI bus
    input  miAddr_t     miAddr,
    input  miData_t     miDwr,
    input  logic        miWr,
    input  logic        miRd,
    output miData_t     miDrd,
    output logic        miDrdy,

    // Event strobes from the header paths
    input  logic        rxCountStrobe,
    input  logic        rxDiscardStrobe,
    input  logic        txCountStrobe,
    input  logic        txDropStrobe,

    // Control levels
    output logic        rxEnable,
    output logic        txEnable,
    output pktLen_t     minLength,
    output dmaChannel_t channelBase
);

    localparam logic [1:0] ctrlReset = `NETMOD_CTRL_RESET;

    logic      [3:0] cntStrobe;
    logic            cntClear;
    pktCount_t       counters [4];
    miData_t         rdData;

    // ========================================
    // Control registers
    // ========================================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rxEnable    <= ctrlReset[0];
            txEnable    <= ctrlReset[1];
            minLength   <= pktLen_t'(`NETMOD_MIN_LEN_RESET);
            channelBase <= dmaChannel_t'(`NETMOD_CHAN_BASE_RESET);
        end else if (miWr) begin
            case (miAddr)
                regCtrl: begin
                    rxEnable <= miDwr[0];
                    txEnable <= miDwr[1];
                end
                regMinLen:   minLength   <= miDwr[`NETMOD_LEN_WIDTH-1:0];
                regChanBase: channelBase <= miDwr[`NETMOD_CHAN_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    // ========================================
    // Packet counters
    // ========================================

    // Order: rx packets, rx discards, tx packets, tx drops
    assign cntStrobe = {txDropStrobe, txCountStrobe, rxDiscardStrobe, rxCountStrobe};
    assign cntClear  = miWr && (miAddr == regCntClr);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 4; i++) begin
                counters[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                // Clear wins over a same-cycle event
                if (cntClear) begin
                    counters[i] <= '0;
                end else if (cntStrobe[i]) begin
                    counters[i] <= counters[i] + pktCount_t'(1);
                end
            end
        end
    end

    // ========================================
    // Read path
    // ========================================
    always_comb begin
        case (miAddr)
            regCtrl:     rdData = {30'd0, txEnable, rxEnable};
            regMinLen:   rdData = miData_t'(minLength);
            regChanBase: rdData = miData_t'(channelBase);
            regRxPkts:   rdData = counters[0];
            regRxDisc:   rdData = counters[1];
            regTxPkts:   rdData = counters[2];
            regTxDrop:   rdData = counters[3];
            default:     rdData = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            miDrdy <= 1'b0;
        end else begin
            miDrdy <= miRd;
        end
    end

    always_ff @(posedge clk) begin
        if (miRd) begin
            miDrd <= rdData;
        end
    end

endmodule

// File: design/netmodTop.sv
// Network module header path top level
// Joins the receive and transmit header stages with the MI register file
`timescale 1ns/1ps

module netmodTop import netmod_pkg::*; (
    input  logic        clk,
    input  logic        rstN,

    input  logic        ethRxValid,
    input  pktLen_t     ethRxLength,
    input  pktMeta_t    ethRxMeta,
    input  logic        ethRxError,

    output logic        dmaRxValid,
    output pktLen_t     dmaRxLength,
    output dmaChannel_t dmaRxChannel,
    output pktMeta_t    dmaRxMeta,
    output logic        dmaRxDiscard,

    input  logic        dmaTxValid,
    input  pktLen_t     dmaTxLength,
    input  dmaChannel_t dmaTxChannel,
    input  pktMeta_t    dmaTxMeta,

    output logic        ethTxValid,
    output pktLen_t     ethTxLength,
    output pktMeta_t    ethTxMeta,

    input  miAddr_t     miAddr,
    input  miData_t     miDwr,
    input  logic        miWr,
    input  logic        miRd,
    output miData_t     miDrd,
    output logic        miDrdy
);

    logic        rxEnable;
    logic        txEnable;
    pktLen_t     minLength;
    dmaChannel_t channelBase;
    logic        rxCountStrobe;
    logic        rxDiscardStrobe;
    logic        txCountStrobe;
    logic        txDropStrobe;

    rxHeaderPath u_rxHeaderPath (
        .clk             (clk),
        .rstN            (rstN),
        .ethRxValid      (ethRxValid),
        .ethRxLength     (ethRxLength),
        .ethRxMeta       (ethRxMeta),
        .ethRxError      (ethRxError),
        .rxEnable        (rxEnable),
        .minLength       (minLength),
        .channelBase     (channelBase),
        .dmaRxValid      (dmaRxValid),
        .dmaRxLength     (dmaRxLength),
        .dmaRxChannel    (dmaRxChannel),
        .dmaRxMeta       (dmaRxMeta),
        .dmaRxDiscard    (dmaRxDiscard),
        .rxCountStrobe   (rxCountStrobe),
        .rxDiscardStrobe (rxDiscardStrobe)
    );

    txHeaderPath u_txHeaderPath (
        .clk           (clk),
        .rstN          (rstN),
        .dmaTxValid    (dmaTxValid),
        .dmaTxLength   (dmaTxLength),
        .dmaTxChannel  (dmaTxChannel),
        .dmaTxMeta     (dmaTxMeta),
        .txEnable      (txEnable),
        .ethTxValid    (ethTxValid),
        .ethTxLength   (ethTxLength),
        .ethTxMeta     (ethTxMeta),
        .txCountStrobe (txCountStrobe),
        .txDropStrobe  (txDropStrobe)
    );

    miRegisters u_miRegisters (
        .clk             (clk),
        .rstN            (rstN),
        .miAddr          (miAddr),
        .miDwr           (miDwr),
        .miWr            (miWr),
        .miRd            (miRd),
        .miDrd           (miDrd),
        .miDrdy          (miDrdy),
        .rxCountStrobe   (rxCountStrobe),
        .rxDiscardStrobe (rxDiscardStrobe),
        .txCountStrobe   (txCountStrobe),
        .txDropStrobe    (txDropStrobe),
        .rxEnable        (rxEnable),
        .txEnable        (txEnable),
        .minLength       (minLength),
        .channelBase     (channelBase)
    );

endmodule

// File: tests/tbClock.sv
// Testbench clock and reset source
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for four rising edges, released just after the edge
    initial begin
        rstN = 1'b0;
        repeat (4) @(posedge clk);
        #1 rstN = 1'b1;
    end

endmodule

// File: tests/netmodChecker.sv
// Monitor for the DMA receive and Ethernet transmit header outputs
// Compares each output against the expected queues and counts mismatches
`timescale 1ns/1ps

module netmodChecker import netmod_pkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        dmaRxValid,
    input  pktLen_t     dmaRxLength,
    input  dmaChannel_t dmaRxChannel,
    input  pktMeta_t    dmaRxMeta,
    input  logic        dmaRxDiscard,
    input  logic        ethTxValid,
    input  pktLen_t     ethTxLength,
    input  pktMeta_t    ethTxMeta
);

    localparam int rxBits = $bits(pktLen_t) + $bits(dmaChannel_t) + $bits(pktMeta_t) + 1;
    localparam int txBits = $bits(pktLen_t) + $bits(pktMeta_t);

    logic [rxBits-1:0] rxQueue [$];
    logic [txBits-1:0] txQueue [$];

    int rxErrors       = 0;
    int txErrors       = 0;
    int readErrors     = 0;
    int leftoverErrors = 0;

    task automatic pushRx(input logic [rxBits-1:0] hdr);
        rxQueue.push_back(hdr);
    endtask

    task automatic pushTx(input logic [txBits-1:0] hdr);
        txQueue.push_back(hdr);
    endtask

    function automatic int fieldDiffers(input string name, input logic [31:0] expected,
                                        input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            return 1;
        end
        return 0;
    endfunction

    // MI readback compare
    task automatic checkWord(input string name, input miData_t expected, input miData_t actual);
        readErrors += fieldDiffers(name, expected, actual);
    endtask

    function automatic bit queuesEmpty();
        return (rxQueue.size() == 0) && (txQueue.size() == 0);
    endfunction

    task automatic reportLeftovers();
        if (rxQueue.size() != 0) begin
            leftoverErrors++;
            $display("%0d expected DMA receive headers never arrived", rxQueue.size());
        end
        if (txQueue.size() != 0) begin
            leftoverErrors++;
            $display("%0d expected Ethernet transmit headers never arrived", txQueue.size());
        end
    endtask

    function automatic int errorCount();
        return rxErrors + txErrors + readErrors + leftoverErrors;
    endfunction

    // ========================================
    // Output compare
    // ========================================

    // Outputs change on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin : compareRx
        pktLen_t     eLen;
        dmaChannel_t eChan;
        pktMeta_t    eMeta;
        logic        eDisc;
        if (rstN && dmaRxValid) begin
            if (rxQueue.size() == 0) begin
                rxErrors++;
                $display("Unexpected DMA receive header at %0t with none expected", $time);
            end else begin
                {eLen, eChan, eMeta, eDisc} = rxQueue.pop_front();
                rxErrors += fieldDiffers("dmaRxLength", 32'(eLen), 32'(dmaRxLength));
                rxErrors += fieldDiffers("dmaRxChannel", 32'(eChan), 32'(dmaRxChannel));
                rxErrors += fieldDiffers("dmaRxMeta", 32'(eMeta), 32'(dmaRxMeta));
                rxErrors += fieldDiffers("dmaRxDiscard", 32'(eDisc), 32'(dmaRxDiscard));
            end
        end
    end

    always @(negedge clk) begin : compareTx
        pktLen_t  eLen;
        pktMeta_t eMeta;
        if (rstN && ethTxValid) begin
            if (txQueue.size() == 0) begin
                txErrors++;
                $display("Unexpected Ethernet transmit header at %0t with none expected", $time);
            end else begin
                {eLen, eMeta} = txQueue.pop_front();
                txErrors += fieldDiffers("ethTxLength", 32'(eLen), 32'(ethTxLength));
                txErrors += fieldDiffers("ethTxMeta", 32'(eMeta), 32'(ethTxMeta));
            end
        end
    end

endmodule

// File: tests/netmod_properties.sv
// Concurrent checks on MI read latency and the header valid strobes
`timescale 1ns/1ps

module netmodProperties (
    input logic clk,
    input logic rstN,
    input logic miRd,
    input logic miDrdy,
    input logic ethRxValid,
    input logic dmaRxValid,
    input logic dmaTxValid,
    input logic ethTxValid
);

    int failCount = 0;

    // Read data strobe exactly one cycle after the request
    assert property (@(posedge clk) disable iff (!rstN) miRd |=> miDrdy)
        else begin
            $error("miDrdy did not follow miRd after one cycle");
            failCount++;
        end

    assert property (@(posedge clk) disable iff (!rstN) miDrdy |-> $past(miRd))
        else begin
            $error("miDrdy high without a read one cycle earlier");
            failCount++;
        end

    assert property (@(posedge clk) $rose(rstN) |-> !dmaRxValid && !ethTxValid && !miDrdy)
        else begin
            $error("Valid output high in the first cycle after reset");
            failCount++;
        end

    // Outputs only ever follow an input strobe
    assert property (@(posedge clk) disable iff (!rstN)
                     (dmaRxValid |-> $past(ethRxValid)) and (ethTxValid |-> $past(dmaTxValid)))
        else begin
            $error("Header output without an input strobe one cycle earlier");
            failCount++;
        end

endmodule

bind netmodTop netmodProperties u_netmodProperties (
    .clk        (clk),
    .rstN       (rstN),
    .miRd       (miRd),
    .miDrdy     (miDrdy),
    .ethRxValid (ethRxValid),
    .dmaRxValid (dmaRxValid),
    .dmaTxValid (dmaTxValid),
    .ethTxValid (ethTxValid)
);

// File: tests/netmodTestbench.sv
// Testbench for the network module header path
// Random header traffic, MI register access and counter readback
`timescale 1ns/1ps
`include "netmod_settings.svh"

module netmodTestbench import netmod_pkg::*; ();

    localparam int rxBits       = $bits(pktLen_t) + $bits(dmaChannel_t) + $bits(pktMeta_t) + 1;
    localparam int txBits       = $bits(pktLen_t) + $bits(pktMeta_t);
    localparam int readTimeout  = 20;
    localparam int drainTimeout = 50;

    logic        clk;
    logic        rstN;
    logic        ethRxValid;
    pktLen_t     ethRxLength;
    pktMeta_t    ethRxMeta;
    logic        ethRxError;
    logic        dmaRxValid;
    pktLen_t     dmaRxLength;
    dmaChannel_t dmaRxChannel;
    pktMeta_t    dmaRxMeta;
    logic        dmaRxDiscard;
    logic        dmaTxValid;
    pktLen_t     dmaTxLength;
    dmaChannel_t dmaTxChannel;
    pktMeta_t    dmaTxMeta;
    logic        ethTxValid;
    pktLen_t     ethTxLength;
    pktMeta_t    ethTxMeta;
    miAddr_t     miAddr;
    miData_t     miDwr;
    logic        miWr;
    logic        miRd;
    miData_t     miDrd;
    logic        miDrdy;

    logic [31:0] rngState;
    int          timeoutCount;
    int          errorTotal;

    // Shadow copies of the control registers
    logic        rxEnableReg;
    logic        txEnableReg;
    pktLen_t     minLengthReg;
    dmaChannel_t channelBaseReg;

    // What the hardware counters should hold
    pktCount_t   rxPkts;
    pktCount_t   rxDisc;
    pktCount_t   txPkts;
    pktCount_t   txDrop;

    tbClock u_tbClock (
        .clk  (clk),
        .rstN (rstN)
    );

    netmodTop u_netmodTop (.*);

    netmodChecker u_netmodChecker (
        .clk          (clk),
        .rstN         (rstN),
        .dmaRxValid   (dmaRxValid),
        .dmaRxLength  (dmaRxLength),
        .dmaRxChannel (dmaRxChannel),
        .dmaRxMeta    (dmaRxMeta),
        .dmaRxDiscard (dmaRxDiscard),
        .ethTxValid   (ethTxValid),
        .ethTxLength  (ethTxLength),
        .ethTxMeta    (ethTxMeta)
    );

    // ========================================
    // Reference model
    // ========================================
    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Packed as length, channel, meta, discard
    function automatic logic [rxBits-1:0] expectRx(input pktLen_t len, input pktMeta_t meta,
                                                   input logic err);
        int   chan;
        logic discard;
        chan    = (int'(meta) % `NETMOD_CHANNELS + int'(channelBaseReg)) % `NETMOD_CHANNELS;
        discard = err || !rxEnableReg || (int'(len) < int'(minLengthReg))
                  || (int'(len) > `NETMOD_PKT_MTU);
        return {len, dmaChannel_t'(chan), meta, discard};
    endfunction

    // Channel is stripped, length and metadata pass unchanged
    function automatic logic [txBits-1:0] expectTx(input pktLen_t len, input pktMeta_t meta);
        return {len, meta};
    endfunction

    // ========================================
    // Bus tasks
    // ========================================
    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic miWrite(input miAddr_t addr, input miData_t data);
        miAddr = addr;
        miDwr  = data;
        miWr   = 1'b1;
        stepCycle();
        miWr   = 1'b0;
        case (addr)
            regCtrl: begin
                rxEnableReg = data[0];
                txEnableReg = data[1];
            end
            regMinLen:   minLengthReg   = pktLen_t'(data);
            regChanBase: channelBaseReg = dmaChannel_t'(data);
            regCntClr: begin
                rxPkts = '0;
                rxDisc = '0;
                txPkts = '0;
                txDrop = '0;
            end
            default: ;
        endcase
    endtask

    task automatic miRead(input miAddr_t addr, output miData_t data);
        int waited;
        miAddr = addr;
        miRd   = 1'b1;
        stepCycle();
        miRd   = 1'b0;
        waited = 0;
        while (!miDrdy && waited < readTimeout) begin
            stepCycle();
            waited++;
        end
        if (!miDrdy) begin
            $display("Timeout: no read data returned for MI address 0x%0h", addr);
            timeoutCount++;
        end
        data = miDrd;
    endtask

    task automatic checkRead(input miAddr_t addr, input string name, input miData_t expected);
        miData_t value;
        miRead(addr, value);
        u_netmodChecker.checkWord(name, expected, value);
    endtask

    task automatic checkCounters();
        checkRead(regRxPkts, "RX_PKTS", rxPkts);
        checkRead(regRxDisc, "RX_DISC", rxDisc);
        checkRead(regTxPkts, "TX_PKTS", txPkts);
        checkRead(regTxDrop, "TX_DROP", txDrop);
    endtask

    // Random receive and transmit headers, each present on about half the cycles
    task automatic runTraffic(input int cycles);
        logic [31:0]       rxRand;
        logic [31:0]       txRand;
        logic [rxBits-1:0] hdr;
        for (int i = 0; i < cycles; i++) begin
            rngState = xorshift32(rngState);
            rxRand   = rngState;
            rngState = xorshift32(rngState);
            txRand   = rngState;

            ethRxValid   = rxRand[0];
            // Short lengths often enough to hit the minimum-length rule
            ethRxLength  = rxRand[1] ? pktLen_t'(rxRand[31:24]) : pktLen_t'(rxRand[31:18]);
            ethRxMeta    = pktMeta_t'(rxRand[15:8]);
            ethRxError   = (rxRand[7:5] == 3'd0);
            dmaTxValid   = txRand[0];
            dmaTxLength  = pktLen_t'(txRand[31:18]);
            dmaTxChannel = dmaChannel_t'(txRand[3:1]);
            dmaTxMeta    = pktMeta_t'(txRand[15:8]);

            if (ethRxValid) begin
                hdr = expectRx(ethRxLength, ethRxMeta, ethRxError);
                u_netmodChecker.pushRx(hdr);
                rxPkts++;
                if (hdr[0]) begin
                    rxDisc++;
                end
            end
            if (dmaTxValid) begin
                if (txEnableReg) begin
                    u_netmodChecker.pushTx(expectTx(dmaTxLength, dmaTxMeta));
                    txPkts++;
                end else begin
                    txDrop++;
                end
            end
            stepCycle();
        end
        ethRxValid = 1'b0;
        dmaTxValid = 1'b0;
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        int waited;
        ethRxValid     = 1'b0;
        ethRxLength    = '0;
        ethRxMeta      = '0;
        ethRxError     = 1'b0;
        dmaTxValid     = 1'b0;
        dmaTxLength    = '0;
        dmaTxChannel   = '0;
        dmaTxMeta      = '0;
        miAddr         = '0;
        miDwr          = '0;
        miWr           = 1'b0;
        miRd           = 1'b0;
        rngState       = 32'h4b33;
        timeoutCount   = 0;
        rxEnableReg    = 1'b1;
        txEnableReg    = 1'b1;
        minLengthReg   = pktLen_t'(`NETMOD_MIN_LEN_RESET);
        channelBaseReg = '0;
        rxPkts         = '0;
        rxDisc         = '0;
        txPkts         = '0;
        txDrop         = '0;

        waited = 0;
        while (rstN !== 1'b1 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (rstN !== 1'b1) begin
            $display("Timeout: reset was never released");
            timeoutCount++;
        end
        stepCycle();

        // Reset values, an unmapped address and cleared counters
        checkRead(regCtrl, "CTRL", 32'h3);
        checkRead(regMinLen, "MIN_LEN", `NETMOD_MIN_LEN_RESET);
        checkRead(regChanBase, "CHAN_BASE", 32'h0);
        checkRead(32'h0C, "unmapped 0x0C", 32'h0);
        checkCounters();

        runTraffic(60);

        // New channel offset and length threshold
        miWrite(regChanBase, 32'h5);
        miWrite(regMinLen, 32'd200);
        checkRead(regChanBase, "CHAN_BASE", 32'h5);
        checkRead(regMinLen, "MIN_LEN", 32'd200);
        runTraffic(60);

        miWrite(regCtrl, 32'h2);
        checkRead(regCtrl, "CTRL", 32'h2);
        runTraffic(30);
        miWrite(regCtrl, 32'h1);
        checkRead(regCtrl, "CTRL", 32'h1);
        runTraffic(30);
        miWrite(regCtrl, 32'h3);
        runTraffic(40);

        waited = 0;
        while (!u_netmodChecker.queuesEmpty() && waited < drainTimeout) begin
            stepCycle();
            waited++;
        end

        checkCounters();
        miWrite(regCntClr, 32'h1);
        checkCounters();

        u_netmodChecker.reportLeftovers();
        errorTotal = u_netmodChecker.errorCount() + timeoutCount
                     + u_netmodTop.u_netmodProperties.failCount;
        $display("Errors: %0d total (%0d compare, %0d timeout, %0d assertion)",
                 errorTotal, u_netmodChecker.errorCount(), timeoutCount,
                 u_netmodTop.u_netmodProperties.failCount);
        if (errorTotal == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: netmod.f
+incdir+design
design/netmod_pkg.sv
design/rxHeaderPath.sv
design/txHeaderPath.sv
design/miRegisters.sv
design/netmodTop.sv
tests/tbClock.sv
tests/netmodChecker.sv
tests/netmod_properties.sv
tests/netmodTestbench.sv

// File: Makefile
# Verilator build for the network module header path

VERILATOR ?= verilator
TOP       ?= netmodTestbench
RTL_TOP   ?= netmodTop
FILELIST  ?= netmod.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)

sim: build
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
